//--- include/ctrlPkg.sv
/*
  Shared definitions for the processor control unit.
  Holds the field types, the ALU select and operation codes, the opcode
  map and the enums for instruction classes and sequencer states.
  Every RTL file takes what it needs through a wildcard import.
*/

package ctrlPkg;

	// ------------------------------------------------------------
	// field and value types
	// ------------------------------------------------------------
	typedef logic [3:0]  opcodeT;     // IR[3:0]
	typedef logic [3:0]  regFieldT;   // IR[7:4]
	typedef logic [15:0] cycleCountT;
	typedef logic [2:0]  aluSrcT;     // second operand select
	typedef logic [2:0]  aluOpT;

	// second ALU operand
	localparam aluSrcT srcReg       = 3'd0;
	localparam aluSrcT srcOne       = 3'd1; // pc increment
	localparam aluSrcT srcBranchImm = 3'd2;
	localparam aluSrcT srcOriImm    = 3'd3;
	localparam aluSrcT srcShiftImm  = 3'd4;

	localparam aluOpT aluAdd   = 3'd0;
	localparam aluOpT aluSub   = 3'd1;
	localparam aluOpT aluOr    = 3'd2;
	localparam aluOpT aluNand  = 3'd3;
	localparam aluOpT aluShift = 3'd4;

	// ------------------------------------------------------------
	// opcode map
	// ------------------------------------------------------------
	localparam opcodeT opLoad  = 4'b0000;
	localparam opcodeT opMisc  = 4'b0001; // stop and nop, told apart by IR[7:4]
	localparam opcodeT opStore = 4'b0010;
	localparam opcodeT opAdd   = 4'b0100;
	localparam opcodeT opBz    = 4'b0101;
	localparam opcodeT opSub   = 4'b0110;
	localparam opcodeT opNand  = 4'b1000;
	localparam opcodeT opBnz   = 4'b1001;
	localparam opcodeT opBpz   = 4'b1101;

	// shift and ori carry operand bits in the upper opcode bits
	localparam logic [2:0] shiftLowBits = 3'b011;
	localparam logic [2:0] oriLowBits   = 3'b111;

	localparam regFieldT regStop = 4'b0000;
	localparam regFieldT regNop  = 4'b1000;

	typedef enum logic [3:0] {
		clsAdd, clsSub, clsNand, clsShift, clsOri, clsLoad, clsStore,
		clsBz, clsBnz, clsBpz, clsNop, clsStop, clsIllegal
	} opClassE;

	typedef enum logic [4:0] {
		stReset, stFetch, stDecode, stAsn, stAluWrite, stShift,
		stOriRead, stOriAlu, stOriWrite, stLoadRead, stLoadWrite,
		stStore, stBpz, stBz, stBnz, stNop, stStop
	} cpuStateE;

endpackage

//--- verilog/ctrlIf.sv
/*
  Control-group buses between the control generators and the top level.
  Each generator drives its group through the source modport; the
  datapath side reads it through the sink modport.
*/
`timescale 1ns/1ps

// pc, memory and instruction register controls
interface memCtrlIf ();
	logic pcWrite;
	logic addrSel;  // 1 selects the pc as memory address
	logic memRead;
	logic memWrite;
	logic irLoad;
	logic mdrLoad;

	modport source (output pcWrite, addrSel, memRead, memWrite, irLoad, mdrLoad);
	modport sink (input pcWrite, addrSel, memRead, memWrite, irLoad, mdrLoad);
endinterface

// ALU operand, operation and result controls
interface aluCtrlIf import ctrlPkg::*; ();
	logic   alu1;
	aluSrcT alu2;
	aluOpT  aluOp;
	logic   aluOutWrite;
	logic   flagWrite;   // updates N and Z

	modport source (output alu1, alu2, aluOp, aluOutWrite, flagWrite);
	modport sink (input alu1, alu2, aluOp, aluOutWrite, flagWrite);
endinterface

// register file port selects and write controls
interface regCtrlIf ();
	logic r1Sel;
	logic r2Sel;
	logic r1r2Load;
	logic rfWrite;
	logic regIn;    // 1 writes the MDR instead of ALUout

	modport source (output r1Sel, r2Sel, r1r2Load, rfWrite, regIn);
	modport sink (input r1Sel, r2Sel, r1r2Load, rfWrite, regIn);
endinterface

//--- verilog/instrDecoder.sv
/*
  Instruction classifier.
  Maps the opcode and register field of the instruction register to one
  instruction class. The sequencer branches on it in the decode cycle
  and the ALU control uses it to pick the operation.
*/
`timescale 1ns/1ps

module instrDecoder
	import ctrlPkg::*;
(
	input  opcodeT   opcode,
	input  regFieldT regField,
	output opClassE  opClass
);

	always_comb
	begin
		// full opcodes win over the low-bit patterns
		if (opcode == opAdd)
			opClass = clsAdd;
		else if (opcode == opSub)
			opClass = clsSub;
		else if (opcode == opNand)
			opClass = clsNand;
		else if (opcode[2:0] == shiftLowBits)
			opClass = clsShift;
		else if (opcode[2:0] == oriLowBits)
			opClass = clsOri;
		else if (opcode == opLoad)
			opClass = clsLoad;
		else if (opcode == opStore)
			opClass = clsStore;
		else if (opcode == opBpz)
			opClass = clsBpz;
		else if (opcode == opBz)
			opClass = clsBz;
		else if (opcode == opBnz)
			opClass = clsBnz;
		else if (opcode == opMisc && regField == regStop)
			opClass = clsStop;
		else if (opcode == opMisc && regField == regNop)
			opClass = clsNop;
		else
			opClass = clsIllegal; // back through reset
	end

endmodule

//--- verilog/cycleSequencer.sv
/*
  Multi-cycle sequencer.
  Steps each instruction through fetch, decode and its execute cycles,
  one state per clock. Also counts cycles until the processor stops.
*/
`timescale 1ns/1ps

module cycleSequencer
	import ctrlPkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  opClassE    opClass,
	output cpuStateE   state,
	output cycleCountT cycleCount
);

	cpuStateE nextState;

	// ------------------------------------------------------------
	// next-state logic
	// ------------------------------------------------------------
	always_comb
	begin
		case (state)
			stReset:     nextState = stFetch;
			stFetch:     nextState = stDecode;
			stDecode:
			begin
				case (opClass)
					clsAdd, clsSub, clsNand: nextState = stAsn;
					clsShift: nextState = stShift;
					clsOri:   nextState = stOriRead;
					clsLoad:  nextState = stLoadRead;
					clsStore: nextState = stStore;
					clsBpz:   nextState = stBpz;
					clsBz:    nextState = stBz;
					clsBnz:   nextState = stBnz;
					clsNop:   nextState = stNop;
					clsStop:  nextState = stStop;
					default:  nextState = stReset; // undefined opcode
				endcase
			end
			stAsn:       nextState = stAluWrite;
			stShift:     nextState = stAluWrite; // shares the write cycle
			stAluWrite:  nextState = stFetch;
			stOriRead:   nextState = stOriAlu;
			stOriAlu:    nextState = stOriWrite;
			stOriWrite:  nextState = stFetch;
			stLoadRead:  nextState = stLoadWrite;
			stLoadWrite: nextState = stFetch;
			stStop:      nextState = stStop; // only reset leaves
			default:     nextState = stFetch; // store, branches, nop
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= stReset;
		else
			state <= nextState;
	end

	// ------------------------------------------------------------
	// cycle counter, frozen in stop
	// ------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			cycleCount <= '0;
		else if (state != stStop)
			cycleCount <= cycleCount + 16'd1; // wraps at 16 bits
	end

	stopHolds: assert property (@(posedge clock) disable iff (reset)
		state == stStop |=> state == stStop)
		else $error("sequencer left stStop without reset");

	countFrozen: assert property (@(posedge clock) disable iff (reset)
		state == stStop |=> $stable(cycleCount))
		else $error("cycleCount moved while stopped");

endmodule

//--- verilog/pcMemControl.sv
/*
  Program counter and memory control generator.
  Drives the pc write, address select, memory strobes and the IR and MDR
  loads for each state, and resolves the conditional branches from the
  N and Z flags.
*/
`timescale 1ns/1ps

module pcMemControl
	import ctrlPkg::*;
(
	input  cpuStateE        state,
	input  logic            negFlag,
	input  logic            zeroFlag,
	memCtrlIf.source        mem
);

	always_comb
	begin
		mem.pcWrite  = 1'b0;
		mem.addrSel  = 1'b0;
		mem.memRead  = 1'b0;
		mem.memWrite = 1'b0;
		mem.irLoad   = 1'b0;
		mem.mdrLoad  = 1'b0;

		case (state)
			stFetch:
			begin
				mem.pcWrite = 1'b1; // pc + 1 from the ALU
				mem.addrSel = 1'b1;
				mem.memRead = 1'b1;
				mem.irLoad  = 1'b1;
			end
			stLoadRead:
			begin
				mem.memRead = 1'b1;
				mem.mdrLoad = 1'b1;
			end
			stStore:     mem.memWrite = 1'b1;
			stBpz:       mem.pcWrite = ~negFlag; // taken when not negative
			stBz:        mem.pcWrite = zeroFlag;
			stBnz:       mem.pcWrite = ~zeroFlag;
			default:     ;
		endcase

		// one memory port, one access per cycle
		memOneAccess: assert (!(mem.memRead && mem.memWrite))
			else $error("memRead and memWrite both high in %s", state.name());
	end

endmodule

//--- verilog/aluControl.sv
/*
  ALU control generator.
  Selects the ALU operands and operation per state and raises the
  ALUout and flag writes. In the add, sub and nand cycle the operation
  follows the decoded instruction class.
*/
`timescale 1ns/1ps

module aluControl
	import ctrlPkg::*;
(
	input  cpuStateE        state,
	input  opClassE         opClass,
	aluCtrlIf.source        alu
);

	always_comb
	begin
		alu.alu1        = 1'b0;
		alu.alu2        = srcReg;
		alu.aluOp       = aluAdd;
		alu.aluOutWrite = 1'b0;
		alu.flagWrite   = 1'b0;

		case (state)
			stFetch:     alu.alu2 = srcOne; // pc increment
			stAsn:
			begin
				alu.alu1        = 1'b1;
				alu.aluOutWrite = 1'b1;
				alu.flagWrite   = 1'b1;
				case (opClass)
					clsSub:  alu.aluOp = aluSub;
					clsNand: alu.aluOp = aluNand;
					default: alu.aluOp = aluAdd;
				endcase
			end
			stShift:
			begin
				alu.alu1        = 1'b1;
				alu.alu2        = srcShiftImm;
				alu.aluOp       = aluShift;
				alu.aluOutWrite = 1'b1;
				alu.flagWrite   = 1'b1;
			end
			stOriAlu:
			begin
				alu.alu1        = 1'b1;
				alu.alu2        = srcOriImm;
				alu.aluOp       = aluOr;
				alu.aluOutWrite = 1'b1;
				alu.flagWrite   = 1'b1;
			end
			stLoadWrite: alu.aluOutWrite = 1'b1;
			stBpz, stBz, stBnz, stNop, stStop:
				alu.alu2 = srcBranchImm; // pc + offset
			default:     ;
		endcase

		flagNeedsResult: assert (!alu.flagWrite || alu.aluOutWrite)
			else $error("flagWrite without aluOutWrite in %s", state.name());
	end

endmodule

//--- verilog/regFileControl.sv
/*
  Register file control generator.
  Raises the operand register loads, the R1 port select and the register
  file write, and picks MDR or ALUout as write data.
*/
`timescale 1ns/1ps

module regFileControl
	import ctrlPkg::*;
(
	input  cpuStateE        state,
	regCtrlIf.source        regs
);

	always_comb
	begin
		regs.r1Sel    = 1'b0;
		regs.r2Sel    = 1'b0; // no scalar state uses it
		regs.r1r2Load = 1'b0;
		regs.rfWrite  = 1'b0;
		regs.regIn    = 1'b0;

		case (state)
			stDecode:    regs.r1r2Load = 1'b1; // operands for cycle 3
			stOriRead:
			begin
				regs.r1r2Load = 1'b1;
				regs.r1Sel    = 1'b1; // ori works on the fixed register
			end
			stOriWrite:
			begin
				regs.rfWrite = 1'b1;
				regs.r1Sel   = 1'b1;
			end
			stAluWrite:  regs.rfWrite = 1'b1;
			stLoadWrite:
			begin
				regs.rfWrite = 1'b1;
				regs.regIn   = 1'b1; // write back from the MDR
			end
			default:     ;
		endcase
	end

endmodule

//--- verilog/controlUnit.sv
/*
  Control unit top level.
  Connects the decoder, the sequencer and the three control generators
  and brings the control groups out as plain ports for the datapath.
*/
`timescale 1ns/1ps

module controlUnit
	import ctrlPkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  opcodeT     instr,
	input  regFieldT   instrRegs,
	input  logic       negFlag,
	input  logic       zeroFlag,
	output logic       pcWrite,
	output logic       addrSel,
	output logic       memRead,
	output logic       memWrite,
	output logic       irLoad,
	output logic       mdrLoad,
	output logic       r1Sel,
	output logic       r2Sel,
	output logic       r1r2Load,
	output logic       rfWrite,
	output logic       regIn,
	output logic       alu1,
	output logic       aluOutWrite,
	output logic       flagWrite,
	output aluSrcT     alu2,
	output aluOpT      aluOp,
	output cycleCountT cycleCount
);

	opClassE  opClass;
	cpuStateE state;

	memCtrlIf memBus ();
	aluCtrlIf aluBus ();
	regCtrlIf regBus ();

	// ------------------------------------------------------------
	// decode and sequencing
	// ------------------------------------------------------------
	instrDecoder u_instrDecoder (.opcode(instr), .regField(instrRegs), .opClass(opClass));

	cycleSequencer u_cycleSequencer (
		.clock(clock), .reset(reset), .opClass(opClass),
		.state(state), .cycleCount(cycleCount)
	);

	// ------------------------------------------------------------
	// control generators, one per datapath section
	// ------------------------------------------------------------
	pcMemControl u_pcMemControl (
		.state(state), .negFlag(negFlag), .zeroFlag(zeroFlag), .mem(memBus.source)
	);
	aluControl u_aluControl (.state(state), .opClass(opClass), .alu(aluBus.source));
	regFileControl u_regFileControl (.state(state), .regs(regBus.source));

	// flatten the groups onto the datapath ports
	assign pcWrite     = memBus.pcWrite;
	assign addrSel     = memBus.addrSel;
	assign memRead     = memBus.memRead;
	assign memWrite    = memBus.memWrite;
	assign irLoad      = memBus.irLoad;
	assign mdrLoad     = memBus.mdrLoad;
	assign alu1        = aluBus.alu1;
	assign alu2        = aluBus.alu2;
	assign aluOp       = aluBus.aluOp;
	assign aluOutWrite = aluBus.aluOutWrite;
	assign flagWrite   = aluBus.flagWrite;
	assign r1Sel       = regBus.r1Sel;
	assign r2Sel       = regBus.r2Sel;
	assign r1r2Load    = regBus.r1r2Load;
	assign rfWrite     = regBus.rfWrite;
	assign regIn       = regBus.regIn;

endmodule

//--- test/controlUnitTb.sv
/*
  Testbench for the control unit.
  Plays the instruction register and the N and Z flags with random values
  from a fixed seed and checks every DUT output against a cycle model at
  each falling clock edge. The last instruction is stop, then the freeze
  of the outputs and the cycle counter is checked.
*/
`timescale 1ns/1ps

module controlUnitTb
	import ctrlPkg::*;
();

	localparam int numInstr      = 2000;
	localparam int stopCycles    = 40;
	localparam int timeoutCycles = 12000; // 2000 x 5 cycles, stop phase, margin

	typedef enum logic [4:0] {
		mReset, mFetch, mDecode, mAsn, mAluWrite, mShift, mOriRead, mOriAlu,
		mOriWrite, mLoadRead, mLoadWrite, mStore, mBpz, mBz, mBnz, mNop, mStop
	} modelStateE;

	logic       clock;
	logic       reset;
	opcodeT     instr;
	regFieldT   instrRegs;
	logic       negFlag;
	logic       zeroFlag;
	logic       pcWrite, addrSel, memRead, memWrite, irLoad, mdrLoad;
	logic       r1Sel, r2Sel, r1r2Load, rfWrite, regIn;
	logic       alu1, aluOutWrite, flagWrite;
	aluSrcT     alu2;
	aluOpT      aluOp;
	cycleCountT cycleCount;

	// model state and expected outputs
	modelStateE mState;
	cycleCountT mCount;
	logic       ePcWrite, eAddrSel, eMemRead, eMemWrite, eIrLoad, eMdrLoad;
	logic       eR1Sel, eR2Sel, eR1r2Load, eRfWrite, eRegIn;
	logic       eAlu1, eAluOutWrite, eFlagWrite;
	aluSrcT     eAlu2;
	aluOpT      eAluOp;

	integer     seed;
	int         issued;       // instructions handed to the DUT
	int         negCount;
	int         gap;          // cycles since the last irLoad
	int         expGap;
	logic       havePrev;
	int         cycles = 0;

	controlUnit u_controlUnit (.*);

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= timeoutCycles)
		begin
			$display("timeout: the run did not reach stop within %0d cycles", timeoutCycles);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic modelStateE decodeTarget(input opcodeT op, input regFieldT rf);
		if (op == opAdd || op == opSub || op == opNand)
			return mAsn;
		else if (op[2:0] == shiftLowBits)
			return mShift;
		else if (op[2:0] == oriLowBits)
			return mOriRead;
		else if (op == opLoad)
			return mLoadRead;
		else if (op == opStore)
			return mStore;
		else if (op == opBpz)
			return mBpz;
		else if (op == opBz)
			return mBz;
		else if (op == opBnz)
			return mBnz;
		else if (op == opMisc && rf == regStop)
			return mStop;
		else if (op == opMisc && rf == regNop)
			return mNop;
		return mReset; // undefined opcode
	endfunction

	// fetch to fetch length for the first execute state
	function automatic int fetchGap(input modelStateE s);
		case (s)
			mAsn, mShift, mLoadRead: return 4;
			mOriRead:                return 5;
			default:                 return 3;
		endcase
	endfunction

	task automatic modelOutputs();
		{ePcWrite, eAddrSel, eMemRead, eMemWrite, eIrLoad, eMdrLoad} = '0;
		{eR1Sel, eR2Sel, eR1r2Load, eRfWrite, eRegIn} = '0;
		{eAlu1, eAluOutWrite, eFlagWrite} = '0;
		eAlu2  = srcReg;
		eAluOp = aluAdd;
		case (mState)
			mFetch:
			begin
				{ePcWrite, eAddrSel, eMemRead, eIrLoad} = '1;
				eAlu2 = srcOne;
			end
			mDecode:    eR1r2Load = 1'b1;
			mAsn:
			begin
				{eAlu1, eAluOutWrite, eFlagWrite} = '1;
				if (instr == opSub)
					eAluOp = aluSub;
				else if (instr == opNand)
					eAluOp = aluNand;
			end
			mShift:
			begin
				{eAlu1, eAluOutWrite, eFlagWrite} = '1;
				eAlu2  = srcShiftImm;
				eAluOp = aluShift;
			end
			mOriRead:   {eR1r2Load, eR1Sel} = '1;
			mOriAlu:
			begin
				{eAlu1, eAluOutWrite, eFlagWrite} = '1;
				eAlu2  = srcOriImm;
				eAluOp = aluOr;
			end
			mOriWrite:  {eRfWrite, eR1Sel} = '1;
			mAluWrite:  eRfWrite = 1'b1;
			mLoadRead:  {eMemRead, eMdrLoad} = '1;
			mLoadWrite: {eAluOutWrite, eRfWrite, eRegIn} = '1;
			mStore:     eMemWrite = 1'b1;
			mBpz:       ePcWrite = ~negFlag;
			mBz:        ePcWrite = zeroFlag;
			mBnz:       ePcWrite = ~zeroFlag;
			default:    ;
		endcase
		if (mState inside {mBpz, mBz, mBnz, mNop, mStop})
			eAlu2 = srcBranchImm;
	endtask

	task automatic checkOutputs();
		modelOutputs();
		checkValue("pcWrite", 32'(pcWrite), 32'(ePcWrite));
		checkValue("addrSel", 32'(addrSel), 32'(eAddrSel));
		checkValue("memRead", 32'(memRead), 32'(eMemRead));
		checkValue("memWrite", 32'(memWrite), 32'(eMemWrite));
		checkValue("irLoad", 32'(irLoad), 32'(eIrLoad));
		checkValue("mdrLoad", 32'(mdrLoad), 32'(eMdrLoad));
		checkValue("r1Sel", 32'(r1Sel), 32'(eR1Sel));
		checkValue("r2Sel", 32'(r2Sel), 32'(eR2Sel));
		checkValue("r1r2Load", 32'(r1r2Load), 32'(eR1r2Load));
		checkValue("rfWrite", 32'(rfWrite), 32'(eRfWrite));
		checkValue("regIn", 32'(regIn), 32'(eRegIn));
		checkValue("alu1", 32'(alu1), 32'(eAlu1));
		checkValue("aluOutWrite", 32'(aluOutWrite), 32'(eAluOutWrite));
		checkValue("flagWrite", 32'(flagWrite), 32'(eFlagWrite));
		checkValue("alu2", 32'(alu2), 32'(eAlu2));
		checkValue("aluOp", 32'(aluOp), 32'(eAluOp));
		checkValue("cycleCount", 32'(cycleCount), 32'(mCount));
	endtask

	task automatic advanceModel();
		if (reset)
		begin
			mState = mReset;
			mCount = '0;
		end
		else
		begin
			if (mState != mStop)
				mCount = mCount + 16'd1;
			case (mState)
				mFetch:    mState = mDecode;
				mDecode:
				begin
					mState = decodeTarget(instr, instrRegs);
					expGap = fetchGap(mState);
				end
				mAsn, mShift: mState = mAluWrite;
				mOriRead:  mState = mOriAlu;
				mOriAlu:   mState = mOriWrite;
				mLoadRead: mState = mLoadWrite;
				mStop:     mState = mStop;
				default:   mState = mFetch; // reset and last execute cycles
			endcase
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic pickInstruction();
		logic [7:0] pick;

		pick      = 8'($random(seed));
		instr     = pick[3:0];
		instrRegs = pick[7:4];
		if (instr == opMisc && (pick[4] || instrRegs == regStop))
			instrRegs = regNop; // stop only as the last one
	endtask

	task automatic driveInputs();
		if (negCount >= 2)
			reset = 1'b0;
		if (irLoad)
		begin
			if (issued < numInstr)
				pickInstruction();
			else
			begin
				instr     = opMisc;
				instrRegs = regStop;
			end
			issued = issued + 1;
		end
		negFlag  = 1'($random(seed));
		zeroFlag = 1'($random(seed));
	endtask

	task automatic runCycle();
		@(negedge clock);
		negCount = negCount + 1;
		gap = gap + 1;
		if (irLoad)
		begin
			if (havePrev)
				checkValue("fetchGap", 32'(gap), 32'(expGap));
			gap      = 0;
			havePrev = 1'b1;
		end
		checkOutputs();
		driveInputs();
		advanceModel();
	endtask

	initial
	begin
		seed      = 32'hc1bc;
		clock     = 1'b0;
		reset     = 1'b1;
		instr     = opMisc;
		instrRegs = regNop;
		negFlag   = 1'b0;
		zeroFlag  = 1'b0;
		mState    = mReset;
		mCount    = '0;
		issued    = 0;
		negCount  = 0;
		gap       = 0;
		expGap    = 0;
		havePrev  = 1'b0;

		while (mState != mStop)
			runCycle();
		// model holds the count and keeps every control low in stop
		repeat (stopCycles + 1)
			runCycle();

		$display("All tests passed");
		$finish;
	end

endmodule

//--- controlUnit.f
include/ctrlPkg.sv
verilog/ctrlIf.sv
verilog/instrDecoder.sv
verilog/cycleSequencer.sv
verilog/pcMemControl.sv
verilog/aluControl.sv
verilog/regFileControl.sv
verilog/controlUnit.sv
test/controlUnitTb.sv

//--- Makefile
# Verilator build and run of the control unit testbench

SIM = obj_dir/controlUnitSim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): controlUnit.f $(shell cat controlUnit.f)
	verilator --binary --timing --assert -f controlUnit.f --top-module controlUnitTb -o controlUnitSim

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
